// ==== scurve_cfg_pkg.sv ====
package scurve_cfg_pkg;

  //////////////////////////////
  // Scan configuration
  //////////////////////////////

  // Threshold DAC code width
  localparam int DAC_WIDTH = 10;

  // Step index and step count width
  localparam int STEP_WIDTH = 8;

  //////////////////////////////
  // Counter and readout sizes
  //////////////////////////////

  // Channel number field in a data word
  localparam int CHAN_ID_WIDTH = 5;

  // Default per-channel counter width
  localparam int COUNT_WIDTH_DEFAULT = 16;

  // Readout word width
  localparam int WORD_WIDTH = 32;

endpackage

// ==== scurve_word_pkg.sv ====
package scurve_word_pkg;

  import scurve_cfg_pkg::*;

  // Padding left over in each view of the 32-bit word
  localparam int HDR_PAD_WIDTH = WORD_WIDTH - 1 - STEP_WIDTH - DAC_WIDTH;
  localparam int DAT_PAD_WIDTH = WORD_WIDTH - 1 - CHAN_ID_WIDTH - COUNT_WIDTH_DEFAULT;

  //////////////////////////////
  // Header view, one per step
  //////////////////////////////
  typedef struct packed {
    logic                  tag;
    logic [STEP_WIDTH-1:0] step_idx;
    logic [DAC_WIDTH-1:0]  dac_code;
    logic [HDR_PAD_WIDTH-1:0] pad;
  } result_header_t;

  //////////////////////////////
  // Data view, one per channel
  //////////////////////////////
  typedef struct packed {
    logic                           tag;
    logic [CHAN_ID_WIDTH-1:0]       chan_id;
    logic [COUNT_WIDTH_DEFAULT-1:0] trig_count;
    logic [DAT_PAD_WIDTH-1:0]       pad;
  } result_data_t;

  // Tag in bit 31 of both views tells them apart
  typedef union packed {
    result_header_t hdr;
    result_data_t   dat;
  } result_word_u;

endpackage

// ==== scurve_channel_counter.sv ====
`timescale 1ns/1ps

module scurve_channel_counter import scurve_cfg_pkg::*; #(
  parameter int COUNT_WIDTH = COUNT_WIDTH_DEFAULT
) (
  input  logic                   Clk,
  input  logic                   reset_n,
  input  logic                   trigger,
  input  logic                   inject_clk,
  input  logic                   test_active,
  input  logic                   counter_clear,
  input  logic [COUNT_WIDTH-1:0] count_max,
  output logic [COUNT_WIDTH-1:0] pulse_count,
  output logic [COUNT_WIDTH-1:0] trigger_count,
  output logic                   done
);

  //////////////////////////////
  // Input synchronizers
  //////////////////////////////

  // Inject clock, two sync flops plus history for edges
  logic inj_sync1;
  logic inj_sync2;
  logic inj_prev;

  // Trigger idles high, so sync chain resets to one
  logic trig_sync1;
  logic trig_sync2;
  logic trig_prev;

  always_ff @(posedge Clk or negedge reset_n) begin
    if (!reset_n) begin
      inj_sync1 <= 1'b0;
      inj_sync2 <= 1'b0;
      inj_prev  <= 1'b0;
    end else begin
      inj_sync1 <= inject_clk;
      inj_sync2 <= inj_sync1;
      inj_prev  <= inj_sync2;
    end
  end

  always_ff @(posedge Clk or negedge reset_n) begin
    if (!reset_n) begin
      trig_sync1 <= 1'b1;
      trig_sync2 <= 1'b1;
      trig_prev  <= 1'b1;
    end else begin
      trig_sync1 <= trigger;
      trig_sync2 <= trig_sync1;
      trig_prev  <= trig_sync2;
    end
  end

  // Edge strobes in the Clk domain
  logic inj_rise;
  logic inj_fall;
  logic trig_fall;

  assign inj_rise  = inj_sync2 & ~inj_prev;
  assign inj_fall  = ~inj_sync2 & inj_prev;
  assign trig_fall = ~trig_sync2 & trig_prev;

  //////////////////////////////
  // Counting window
  //////////////////////////////

  // Open while the step runs and the channel is not finished
  logic count_en;
  assign count_en = test_active & ~done;

  always_ff @(posedge Clk or negedge reset_n) begin
    if (!reset_n) begin
      pulse_count   <= '0;
      trigger_count <= '0;
    end else if (counter_clear) begin
      pulse_count   <= '0;
      trigger_count <= '0;
    end else if (count_en) begin
      // One count per injection
      if (inj_rise)
        pulse_count <= pulse_count + 1'b1;
      // Triggers only count inside the inject high phase
      if (trig_fall && inj_sync2)
        trigger_count <= trigger_count + 1'b1;
    end
  end

  // Done at the falling edge closing the last injection,
  // so triggers of that pulse are already in the count
  always_ff @(posedge Clk or negedge reset_n) begin
    if (!reset_n)
      done <= 1'b0;
    else if (counter_clear)
      done <= 1'b0;
    else if (test_active && inj_fall && (pulse_count >= count_max))
      done <= 1'b1;
  end

endmodule

// ==== scurve_scan_ctrl.sv ====
`timescale 1ns/1ps

module scurve_scan_ctrl import scurve_cfg_pkg::*, scurve_word_pkg::*; #(
  parameter int NUM_CHANNELS  = 4,
  parameter int COUNT_WIDTH   = COUNT_WIDTH_DEFAULT,
  parameter int SETTLE_CYCLES = 8
) (
  input  logic                              Clk,
  input  logic                              reset_n,
  input  logic                              scan_start,
  input  logic [DAC_WIDTH-1:0]              dac_first,
  input  logic [DAC_WIDTH-1:0]              dac_step,
  input  logic [STEP_WIDTH-1:0]             step_count,
  input  logic [NUM_CHANNELS-1:0]           chan_done,
  input  logic [NUM_CHANNELS*COUNT_WIDTH-1:0] trigger_count,
  input  logic                              fifo_full,
  output logic [DAC_WIDTH-1:0]              dac_code,
  output logic                              test_active,
  output logic                              counter_clear,
  output logic                              wr_en,
  output result_word_u                      wr_data,
  output logic                              scan_busy,
  output logic                              scan_done
);

  // State codes
  localparam logic [2:0] ST_IDLE    = 3'd0;
  localparam logic [2:0] ST_SETTLE  = 3'd1;
  localparam logic [2:0] ST_RUN     = 3'd2;
  localparam logic [2:0] ST_WR_HDR  = 3'd3;
  localparam logic [2:0] ST_WR_DATA = 3'd4;
  localparam logic [2:0] ST_CLEAR   = 3'd5;
  localparam logic [2:0] ST_NEXT    = 3'd6;

  // Settle counter, SETTLE_CYCLES is at least one
  localparam int SETTLE_W = $clog2(SETTLE_CYCLES + 1);
  localparam logic [SETTLE_W-1:0] LAST_SETTLE = SETTLE_W'(SETTLE_CYCLES - 1);

  // Channel index for the data words
  localparam int CHAN_IDX_W = (NUM_CHANNELS > 1) ? $clog2(NUM_CHANNELS) : 1;
  localparam logic [CHAN_IDX_W-1:0] LAST_CHAN = CHAN_IDX_W'(NUM_CHANNELS - 1);

  logic [2:0]            state;
  logic [SETTLE_W-1:0]   settle_cnt;
  logic [STEP_WIDTH-1:0] step_idx;
  logic [CHAN_IDX_W-1:0] chan_idx;
  logic                  last_step;
  logic [COUNT_WIDTH-1:0] chan_count;

  // Scan ends once step_idx+1 reaches step_count; zero steps acts as one
  assign last_step = ({1'b0, step_idx} + 1'b1) >= {1'b0, step_count};

  //////////////////////////////
  // Step sequencing
  //////////////////////////////
  always_ff @(posedge Clk or negedge reset_n) begin
    if (!reset_n) begin
      state       <= ST_IDLE;
      settle_cnt  <= '0;
      step_idx    <= '0;
      chan_idx    <= '0;
      dac_code    <= '0;
      test_active <= 1'b0;
      scan_busy   <= 1'b0;
      scan_done   <= 1'b0;
    end else begin
      scan_done <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (scan_start) begin
            dac_code   <= dac_first;
            step_idx   <= '0;
            settle_cnt <= '0;
            scan_busy  <= 1'b1;
            state      <= ST_SETTLE;
          end
        end
        // Let the threshold settle before the pulser runs
        ST_SETTLE: begin
          if (settle_cnt == LAST_SETTLE) begin
            test_active <= 1'b1;
            state       <= ST_RUN;
          end else begin
            settle_cnt <= settle_cnt + 1'b1;
          end
        end
        // Wait for every channel to finish its injections
        ST_RUN: begin
          if (&chan_done) begin
            test_active <= 1'b0;
            state       <= ST_WR_HDR;
          end
        end
        ST_WR_HDR: begin
          if (!fifo_full) begin
            chan_idx <= '0;
            state    <= ST_WR_DATA;
          end
        end
        // Full FIFO holds the current word in place
        ST_WR_DATA: begin
          if (!fifo_full) begin
            if (chan_idx == LAST_CHAN)
              state <= ST_CLEAR;
            else
              chan_idx <= chan_idx + 1'b1;
          end
        end
        ST_CLEAR: begin
          state <= ST_NEXT;
        end
        ST_NEXT: begin
          if (last_step) begin
            scan_done <= 1'b1;
            scan_busy <= 1'b0;
            state     <= ST_IDLE;
          end else begin
            step_idx   <= step_idx + 1'b1;
            dac_code   <= dac_code + dac_step;
            settle_cnt <= '0;
            state      <= ST_SETTLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // Counters restart once per step
  assign counter_clear = (state == ST_CLEAR);

  //////////////////////////////
  // Result word packing
  //////////////////////////////
  assign chan_count = trigger_count[chan_idx*COUNT_WIDTH +: COUNT_WIDTH];

  // Write strobe never issued into a full FIFO
  assign wr_en = ((state == ST_WR_HDR) || (state == ST_WR_DATA)) && !fifo_full;

  always_comb begin
    wr_data = '0;
    if (state == ST_WR_HDR) begin
      wr_data.hdr.tag      = 1'b1;
      wr_data.hdr.step_idx = step_idx;
      wr_data.hdr.dac_code = dac_code;
    end else begin
      // Count resized to the fixed field of the data view
      wr_data.dat.tag        = 1'b0;
      wr_data.dat.chan_id    = CHAN_ID_WIDTH'(chan_idx);
      wr_data.dat.trig_count = COUNT_WIDTH_DEFAULT'(chan_count);
    end
  end

endmodule

// ==== scurve_result_fifo.sv ====
`timescale 1ns/1ps

module scurve_result_fifo import scurve_word_pkg::*; #(
  parameter int FIFO_DEPTH = 16
) (
  input  logic         Clk,
  input  logic         reset_n,
  input  logic         wr_en,
  input  result_word_u wr_data,
  input  logic         rd_en,
  output result_word_u rd_data,
  output logic         fifo_full,
  output logic         fifo_empty
);

  // Pointer and fill widths, any depth allowed
  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);
  localparam logic [PTR_W-1:0] LAST_PTR  = PTR_W'(FIFO_DEPTH - 1);
  localparam logic [CNT_W-1:0] DEPTH_CNT = CNT_W'(FIFO_DEPTH);

  result_word_u     mem [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] fill;
  logic             push;
  logic             pop;

  // Wrap at the last slot
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    return (ptr == LAST_PTR) ? '0 : ptr + 1'b1;
  endfunction

  // Pops while empty are dropped
  assign push = wr_en && !fifo_full;
  assign pop  = rd_en && !fifo_empty;

  always_ff @(posedge Clk) begin
    if (push)
      mem[wr_ptr] <= wr_data;
  end

  always_ff @(posedge Clk or negedge reset_n) begin
    if (!reset_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      fill   <= '0;
    end else begin
      if (push)
        wr_ptr <= next_ptr(wr_ptr);
      if (pop)
        rd_ptr <= next_ptr(rd_ptr);
      // Simultaneous push and pop keep the fill level
      if (push && !pop)
        fill <= fill + 1'b1;
      else if (pop && !push)
        fill <= fill - 1'b1;
    end
  end

  // Head word shown directly
  assign rd_data    = mem[rd_ptr];
  assign fifo_full  = (fill == DEPTH_CNT);
  assign fifo_empty = (fill == '0);

endmodule

// ==== scurve_top.sv ====
`timescale 1ns/1ps

module scurve_top import scurve_cfg_pkg::*, scurve_word_pkg::*; #(
  parameter int NUM_CHANNELS  = 4,
  parameter int COUNT_WIDTH   = COUNT_WIDTH_DEFAULT,
  parameter int SETTLE_CYCLES = 8,
  parameter int FIFO_DEPTH    = 16
) (
  input  logic                    Clk,
  input  logic                    reset_n,
  input  logic                    scan_start,
  input  logic [DAC_WIDTH-1:0]    dac_first,
  input  logic [DAC_WIDTH-1:0]    dac_step,
  input  logic [STEP_WIDTH-1:0]   step_count,
  input  logic [COUNT_WIDTH-1:0]  count_max,
  input  logic                    inject_clk,
  input  logic [NUM_CHANNELS-1:0] trigger,
  input  logic                    rd_en,
  output logic [DAC_WIDTH-1:0]    dac_code,
  output logic                    inject_enable,
  output logic                    scan_busy,
  output logic                    scan_done,
  output result_word_u            rd_data,
  output logic                    fifo_empty
);

  // Controller to counters
  logic test_active;
  logic counter_clear;

  // Counters to controller
  logic [NUM_CHANNELS-1:0]             chan_done;
  logic [NUM_CHANNELS*COUNT_WIDTH-1:0] trigger_count;

  // Controller to FIFO
  logic         wr_en;
  result_word_u wr_data;
  logic         fifo_full;

  // Pulser gate is the counting window itself
  assign inject_enable = test_active;

  //////////////////////////////
  // Scan controller
  //////////////////////////////
  scurve_scan_ctrl #(
    .NUM_CHANNELS  (NUM_CHANNELS),
    .COUNT_WIDTH   (COUNT_WIDTH),
    .SETTLE_CYCLES (SETTLE_CYCLES)
  ) u_scan_ctrl (
    .Clk           (Clk),
    .reset_n       (reset_n),
    .scan_start    (scan_start),
    .dac_first     (dac_first),
    .dac_step      (dac_step),
    .step_count    (step_count),
    .chan_done     (chan_done),
    .trigger_count (trigger_count),
    .fifo_full     (fifo_full),
    .dac_code      (dac_code),
    .test_active   (test_active),
    .counter_clear (counter_clear),
    .wr_en         (wr_en),
    .wr_data       (wr_data),
    .scan_busy     (scan_busy),
    .scan_done     (scan_done)
  );

  // One counter per channel, all on the shared inject clock
  for (genvar ch = 0; ch < NUM_CHANNELS; ch++) begin : g_chan
    scurve_channel_counter #(
      .COUNT_WIDTH (COUNT_WIDTH)
    ) u_counter (
      .Clk           (Clk),
      .reset_n       (reset_n),
      .trigger       (trigger[ch]),
      .inject_clk    (inject_clk),
      .test_active   (test_active),
      .counter_clear (counter_clear),
      .count_max     (count_max),
      .pulse_count   (),
      .trigger_count (trigger_count[ch*COUNT_WIDTH +: COUNT_WIDTH]),
      .done          (chan_done[ch])
    );
  end

  //////////////////////////////
  // Result FIFO
  //////////////////////////////
  scurve_result_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_result_fifo (
    .Clk        (Clk),
    .reset_n    (reset_n),
    .wr_en      (wr_en),
    .wr_data    (wr_data),
    .rd_en      (rd_en),
    .rd_data    (rd_data),
    .fifo_full  (fifo_full),
    .fifo_empty (fifo_empty)
  );

endmodule

// ==== tb_scurve_properties.sv ====
`timescale 1ns/1ps

module tb_scurve_properties import scurve_cfg_pkg::*; (
  input logic                 Clk,
  input logic                 reset_n,
  input logic [DAC_WIDTH-1:0] dac_code,
  input logic                 test_active,
  input logic                 wr_en,
  input logic                 fifo_full,
  input logic                 scan_busy,
  input logic                 scan_done
);

  //////////////////////////////
  // Scan controller rules
  //////////////////////////////

  // Threshold frozen across the injection window
  a_dac_stable: assert property (
    @(posedge Clk) disable iff (!reset_n)
    (test_active && $past(test_active)) |-> $stable(dac_code)
  ) else $error("dac_code changed while test_active was high");

  // No write into a full FIFO
  a_no_full_write: assert property (
    @(posedge Clk) disable iff (!reset_n)
    !(wr_en && fifo_full)
  ) else $error("wr_en high while fifo_full is high");

  // Done strobe lasts one cycle
  a_done_single: assert property (
    @(posedge Clk) disable iff (!reset_n)
    scan_done |=> !scan_done
  ) else $error("scan_done held longer than one cycle");

  // Busy drops on the same edge that raises done
  a_done_in_scan: assert property (
    @(posedge Clk) disable iff (!reset_n)
    scan_done |-> $past(scan_busy)
  ) else $error("scan_done pulsed outside a scan");

endmodule

bind scurve_scan_ctrl tb_scurve_properties u_props (
  .Clk         (Clk),
  .reset_n     (reset_n),
  .dac_code    (dac_code),
  .test_active (test_active),
  .wr_en       (wr_en),
  .fifo_full   (fifo_full),
  .scan_busy   (scan_busy),
  .scan_done   (scan_done)
);

// ==== tb_scurve.sv ====
`timescale 1ns/1ps

module tb_scurve import scurve_cfg_pkg::*, scurve_word_pkg::*; ();

  //////////////////////////////
  // Bench configuration
  //////////////////////////////
  localparam int NUM_CH     = 4;
  localparam int CNT_W      = 16;
  localparam int SETTLE     = 8;
  // Small FIFO so the slow reader backs the controller up
  localparam int FIFO_DEPTH = 4;
  localparam logic [15:0] LFSR_SEED = 16'd41;

  // Second scan differs in count_max and dac_step
  localparam int S1_STEPS = 4;
  localparam int S1_CM    = 3;
  localparam int S1_DSTEP = 7;
  localparam int S2_STEPS = 3;
  localparam int S2_CM    = 5;
  localparam int S2_DSTEP = 13;

  // Longest pulse period is 19 high plus 13 low
  localparam int MAX_PERIOD  = 32;
  localparam int WATCHDOG_NS = 100 * (200
    + S1_STEPS * (SETTLE + 80 + MAX_PERIOD * (S1_CM + 2))
    + S2_STEPS * (SETTLE + 80 + MAX_PERIOD * (S2_CM + 2)));

  logic                  Clk = 1'b0;
  logic                  reset_n;
  logic                  scan_start;
  logic [DAC_WIDTH-1:0]  dac_first;
  logic [DAC_WIDTH-1:0]  dac_step;
  logic [STEP_WIDTH-1:0] step_count;
  logic [CNT_W-1:0]      count_max;
  logic                  inject_clk;
  logic [NUM_CH-1:0]     trigger;
  logic                  rd_en;
  logic [DAC_WIDTH-1:0]  dac_code;
  logic                  inject_enable;
  logic                  scan_busy;
  logic                  scan_done;
  result_word_u          rd_data;
  logic                  fifo_empty;

  // Current scan settings read by the pulser model
  int cfg_first;
  int cfg_step;
  int cfg_cm;
  int win_base;

  // Expected readout in order as queued by the pulser model
  bit exp_kind[$];
  int exp_idx[$];
  int exp_val[$];
  int win_count  = 0;
  int words_read = 0;

  always #50 Clk = ~Clk;

  scurve_top #(
    .NUM_CHANNELS  (NUM_CH),
    .COUNT_WIDTH   (CNT_W),
    .SETTLE_CYCLES (SETTLE),
    .FIFO_DEPTH    (FIFO_DEPTH)
  ) u_dut (
    .Clk           (Clk),
    .reset_n       (reset_n),
    .scan_start    (scan_start),
    .dac_first     (dac_first),
    .dac_step      (dac_step),
    .step_count    (step_count),
    .count_max     (count_max),
    .inject_clk    (inject_clk),
    .trigger       (trigger),
    .rd_en         (rd_en),
    .dac_code      (dac_code),
    .inject_enable (inject_enable),
    .scan_busy     (scan_busy),
    .scan_done     (scan_done),
    .rd_data       (rd_data),
    .fifo_empty    (fifo_empty)
  );

  //////////////////////////////
  // Random source and failure reporting
  //////////////////////////////

  // 16-bit Galois LFSR with taps 16 14 13 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return (s >> 1) ^ (s[0] ? 16'hB400 : 16'h0000);
  endfunction

  // One step per bit taken; each process keeps its own state
  function automatic int unsigned rand_bits(inout logic [15:0] st, input int n);
    int unsigned r;
    r = 0;
    for (int i = 0; i < n; i++) begin
      st = lfsr_step(st);
      r  = {r[30:0], st[0]};
    end
    return r;
  endfunction

  task automatic report_failure(input string line);
    $display("%s", line);
    $display("TEST FAILED");
    $fatal(1, "stopped at first failure");
  endtask

  task automatic fail_value(input string name, input int got, input int exp);
    report_failure($sformatf("ERROR at %0t: %s is %0d, expected %0d",
                             $time, name, got, exp));
  endtask

  // Head word against the next expected entry
  task automatic check_word(input result_word_u w);
    int k;
    k = words_read;
    assert (k < exp_kind.size())
      else report_failure("FIFO returned a word before any step finished its injections");
    assert (w.hdr.tag == exp_kind[k])
      else fail_value("rd_data.tag", int'(w.hdr.tag), int'(exp_kind[k]));
    if (exp_kind[k]) begin
      assert (int'(w.hdr.step_idx) == exp_idx[k])
        else fail_value("rd_data.hdr.step_idx", int'(w.hdr.step_idx), exp_idx[k]);
      assert (int'(w.hdr.dac_code) == exp_val[k])
        else fail_value("rd_data.hdr.dac_code", int'(w.hdr.dac_code), exp_val[k]);
    end else begin
      assert (int'(w.dat.chan_id) == exp_idx[k])
        else fail_value("rd_data.dat.chan_id", int'(w.dat.chan_id), exp_idx[k]);
      assert (int'(w.dat.trig_count) == exp_val[k])
        else fail_value("rd_data.dat.trig_count", int'(w.dat.trig_count), exp_val[k]);
    end
    words_read = k + 1;
  endtask

  //////////////////////////////
  // Pulser and trigger model
  //////////////////////////////
  initial begin : pulser
    logic [15:0] st;
    int hi;
    int width;
    int gap;
    int npulse;
    int step;
    int ntrig[NUM_CH];
    int trig_acc[NUM_CH];
    st         = LFSR_SEED;
    inject_clk = 1'b0;
    trigger    = '1;
    forever begin
      // Wait for four cycles of enable
      hi = 0;
      while (hi < 4) begin
        @(posedge Clk);
        #1;
        hi = inject_enable ? hi + 1 : 0;
      end
      npulse = 0;
      foreach (trig_acc[ch])
        trig_acc[ch] = 0;
      while (inject_enable) begin
        npulse++;
        width = 12 + int'(rand_bits(st, 3));
        foreach (ntrig[ch]) begin
          ntrig[ch] = int'(rand_bits(st, 2)) % 3;
          // Two triggers need 15 cycles of high phase
          if (ntrig[ch] == 2 && width < 15)
            ntrig[ch] = 1;
        end
        // Trigger low slots at 3..5 and 9..11
        for (int c = 0; c < width; c++) begin
          inject_clk = 1'b1;
          foreach (ntrig[ch])
            trigger[ch] = !((ntrig[ch] >= 1 && c >= 3 && c < 6) ||
                            (ntrig[ch] == 2 && c >= 9 && c < 12));
          @(posedge Clk);
          #1;
        end
        inject_clk = 1'b0;
        trigger    = '1;
        // Only the first count_max pulses count
        if (npulse <= cfg_cm) begin
          foreach (trig_acc[ch])
            trig_acc[ch] += ntrig[ch];
        end
        // Step complete so queue header and channel words
        if (npulse == cfg_cm) begin
          step = win_count - win_base;
          exp_kind.push_back(1'b1);
          exp_idx.push_back(step);
          exp_val.push_back((cfg_first + step * cfg_step) % (1 << DAC_WIDTH));
          foreach (trig_acc[ch]) begin
            exp_kind.push_back(1'b0);
            exp_idx.push_back(ch);
            exp_val.push_back(trig_acc[ch]);
          end
          win_count++;
        end
        gap = 10 + int'(rand_bits(st, 2));
        repeat (gap) begin
          @(posedge Clk);
          #1;
        end
      end
    end
  end

  //////////////////////////////
  // Host reader
  //////////////////////////////
  initial begin : reader
    logic [15:0] st;
    bit pop_now;
    st    = LFSR_SEED;
    rd_en = 1'b0;
    @(posedge reset_n);
    forever begin
      @(posedge Clk);
      #1;
      // Roughly one pop in four
      pop_now = !fifo_empty && (rand_bits(st, 2) == 0);
      if (pop_now)
        check_word(rd_data);
      rd_en = pop_now;
    end
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    report_failure($sformatf("Timeout: scans still running after %0d ns", WATCHDOG_NS));
  end

  task automatic run_scan(input int first, input int dstep, input int steps, input int cm);
    int read_before;
    cfg_first   = first;
    cfg_step    = dstep;
    cfg_cm      = cm;
    win_base    = win_count;
    read_before = words_read;
    dac_first   = DAC_WIDTH'(first);
    dac_step    = DAC_WIDTH'(dstep);
    step_count  = STEP_WIDTH'(steps);
    count_max   = CNT_W'(cm);
    scan_start  = 1'b1;
    @(posedge Clk);
    #1;
    scan_start = 1'b0;
    assert (scan_busy) else report_failure("scan_busy did not rise after scan_start");
    assert (int'(dac_code) == first) else fail_value("dac_code", int'(dac_code), first);
    while (!scan_done) begin
      @(posedge Clk);
      #1;
    end
    assert (!scan_busy) else report_failure("scan_busy still high in the scan_done cycle");
    // Drain whatever the reader has not taken yet
    while (words_read < exp_kind.size() || !fifo_empty) begin
      @(posedge Clk);
      #1;
    end
    assert (words_read - read_before == steps * (NUM_CH + 1))
      else fail_value("words per scan", words_read - read_before, steps * (NUM_CH + 1));
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////
  initial begin : main_seq
    logic [15:0] st;
    int first;
    st         = LFSR_SEED;
    reset_n    = 1'b0;
    scan_start = 1'b0;
    dac_first  = '0;
    dac_step   = '0;
    step_count = '0;
    count_max  = '0;
    cfg_first  = 0;
    cfg_step   = 0;
    cfg_cm     = 0;
    win_base   = 0;
    repeat (2) @(posedge Clk);
    #1;
    reset_n = 1'b1;
    // Idle levels out of reset
    assert (!inject_enable) else fail_value("inject_enable", int'(inject_enable), 0);
    assert (!scan_busy) else fail_value("scan_busy", int'(scan_busy), 0);
    assert (!scan_done) else fail_value("scan_done", int'(scan_done), 0);
    assert (fifo_empty) else fail_value("fifo_empty", int'(fifo_empty), 1);
    first = int'(rand_bits(st, DAC_WIDTH));
    run_scan(first, S1_DSTEP, S1_STEPS, S1_CM);
    // Fresh counts expected with nothing carried over
    first = int'(rand_bits(st, DAC_WIDTH));
    run_scan(first, S2_DSTEP, S2_STEPS, S2_CM);
    $display("TEST OK");
    $finish;
  end

endmodule

// ==== project.f ====
scurve_cfg_pkg.sv
scurve_word_pkg.sv
scurve_channel_counter.sv
scurve_scan_ctrl.sv
scurve_result_fifo.sv
scurve_top.sv
tb_scurve_properties.sv
tb_scurve.sv

// ==== Makefile ====
# Verilator build and run of the S-curve scan testbench

TOP := tb_scurve

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build tb_scurve with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module $(TOP) -f project.f -Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir
